//--- include/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// data and address width
`define WORD_SIZE 16
`define NUM_REGS  4

// opcode field
`define BNE_OP   4'd0
`define BEQ_OP   4'd1
`define ADI_OP   4'd4
`define LHI_OP   4'd6
`define LWD_OP   4'd7
`define SWD_OP   4'd8
`define JMP_OP   4'd9
`define JAL_OP   4'd10
`define RTYPE_OP 4'd15

// func field, register format only
`define FUNC_ADD 6'd0
`define FUNC_SUB 6'd1
`define FUNC_AND 6'd2
`define FUNC_ORR 6'd3
`define FUNC_JPR 6'd25
`define FUNC_WWD 6'd28
`define FUNC_HLT 6'd29

`endif

//--- source/cpu_pkg.sv
package cpu_pkg;

    typedef struct packed {
        logic [3:0] opcode;
        logic [1:0] rs;
        logic [1:0] rt;
        logic [1:0] rd;
        logic [5:0] func;
    } r_fmt_t;

    typedef struct packed {
        logic [3:0] opcode;
        logic [1:0] rs;
        logic [1:0] rt;
        logic [7:0] imm;
    } i_fmt_t;

    typedef struct packed {
        logic [3:0]  opcode;
        logic [11:0] target;
    } j_fmt_t;

    // one instruction word seen through its three formats
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        j_fmt_t j_fmt;
    } instr_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_ORR,
        ALU_PASS
    } alu_op_t;

endpackage

//--- source/control_unit.sv
`include "cpu_defs.svh"

module control_unit import cpu_pkg::*; (
    input  instr_t  id_instruction,
    input  logic    id_valid,
    output logic    reg_dst,
    output logic    alu_src,
    output logic    mem_read,
    output logic    mem_write,
    output logic    mem_to_reg,
    output logic    reg_write,
    output logic    is_branch,
    output logic    is_jump,
    output logic    is_jump_reg,
    output logic    is_link,
    output logic    is_wwd,
    output logic    is_halt,
    output alu_op_t alu_op
);

    logic [3:0] opcode;
    logic [5:0] func;

    assign opcode = id_instruction.r_fmt.opcode;
    assign func = id_instruction.r_fmt.func;

    always_comb begin
        reg_dst = 1'b0;
        alu_src = 1'b0;
        mem_read = 1'b0;
        mem_write = 1'b0;
        mem_to_reg = 1'b0;
        reg_write = 1'b0;
        is_branch = 1'b0;
        is_jump = 1'b0;
        is_jump_reg = 1'b0;
        is_link = 1'b0;
        is_wwd = 1'b0;
        is_halt = 1'b0;
        alu_op = ALU_ADD;
        case (opcode)
            `ADI_OP: begin
                alu_src = 1'b1;
                reg_write = 1'b1;
            end
            `LHI_OP: begin
                alu_op = ALU_PASS;
                reg_write = 1'b1;
            end
            `LWD_OP: begin
                alu_src = 1'b1;
                mem_read = 1'b1;
                mem_to_reg = 1'b1;
                reg_write = 1'b1;
            end
            `SWD_OP: begin
                alu_src = 1'b1;
                mem_write = 1'b1;
            end
            `BNE_OP, `BEQ_OP: begin
                is_branch = 1'b1;
                alu_op = ALU_SUB;
            end
            `JMP_OP: is_jump = 1'b1;
            `JAL_OP: begin
                is_jump = 1'b1;
                is_link = 1'b1;
                reg_write = 1'b1;
                alu_op = ALU_PASS;
            end
            `RTYPE_OP: begin
                case (func)
                    `FUNC_ADD, `FUNC_SUB, `FUNC_AND, `FUNC_ORR: begin
                        reg_dst = 1'b1;
                        reg_write = 1'b1;
                        alu_op = alu_op_t'(func[2:0]);
                    end
                    `FUNC_WWD: begin
                        is_wwd = 1'b1;
                        alu_op = ALU_PASS;
                    end
                    `FUNC_JPR: is_jump_reg = 1'b1;
                    `FUNC_HLT: is_halt = 1'b1;
                    default: ;
                endcase
            end
            default: ;
        endcase
        // a bubble must not write or redirect
        if (!id_valid) begin
            mem_read = 1'b0;
            mem_write = 1'b0;
            reg_write = 1'b0;
            is_branch = 1'b0;
            is_jump = 1'b0;
            is_jump_reg = 1'b0;
            is_wwd = 1'b0;
            is_halt = 1'b0;
        end
    end

endmodule

//--- source/register_file.sv
`include "cpu_defs.svh"

module register_file (
    input  logic                  Clk,
    input  logic                  arst_n,
    input  logic [1:0]            read_addr1,
    input  logic [1:0]            read_addr2,
    input  logic [1:0]            write_addr,
    input  logic [`WORD_SIZE-1:0] write_data,
    input  logic                  write_enable,
    output logic [`WORD_SIZE-1:0] read_data1,
    output logic [`WORD_SIZE-1:0] read_data2
);

    logic [`WORD_SIZE-1:0] regs [`NUM_REGS];

    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable) begin
            regs[write_addr] <= write_data;
        end
    end

    // write-back in the same cycle is visible to decode
    assign read_data1 = (write_enable && write_addr == read_addr1) ? write_data : regs[read_addr1];
    assign read_data2 = (write_enable && write_addr == read_addr2) ? write_data : regs[read_addr2];

endmodule

//--- source/alu.sv
`include "cpu_defs.svh"

module alu import cpu_pkg::*; (
    input  logic [`WORD_SIZE-1:0] operand_a,
    input  logic [`WORD_SIZE-1:0] operand_b,
    input  alu_op_t               alu_op,
    output logic [`WORD_SIZE-1:0] result,
    output logic                  zero
);

    always_comb begin
        case (alu_op)
            ALU_ADD: result = operand_a + operand_b;
            ALU_SUB: result = operand_a - operand_b;
            ALU_AND: result = operand_a & operand_b;
            ALU_ORR: result = operand_a | operand_b;
            // link, LHI and WWD values arrive on operand_a
            default: result = operand_a;
        endcase
    end

    // equality test for BEQ/BNE after a subtract
    assign zero = (result == '0);

endmodule

//--- source/hazard_forward.sv
module hazard_forward (
    input  logic [1:0] ex_rs,
    input  logic [1:0] ex_rt,
    input  logic [1:0] id_rs,
    input  logic [1:0] id_rt,
    input  logic [1:0] ex_rd,
    input  logic [1:0] mem_rd,
    input  logic [1:0] wb_rd,
    input  logic       id_use_rs,
    input  logic       id_use_rt,
    input  logic       ex_mem_read,
    input  logic       mem_reg_write,
    input  logic       wb_reg_write,
    output logic [1:0] forward_a,
    output logic [1:0] forward_b,
    output logic       stall
);

    // 01 takes the memory stage result, 10 the write-back value
    assign forward_a = (mem_reg_write && mem_rd == ex_rs) ? 2'b01 :
                       (wb_reg_write && wb_rd == ex_rs)   ? 2'b10 : 2'b00;
    assign forward_b = (mem_reg_write && mem_rd == ex_rt) ? 2'b01 :
                       (wb_reg_write && wb_rd == ex_rt)   ? 2'b10 : 2'b00;

    // load data is not ready until write-back, so hold decode one cycle
    assign stall = ex_mem_read &&
                   ((id_use_rs && id_rs == ex_rd) || (id_use_rt && id_rt == ex_rd));

endmodule

//--- source/datapath.sv
`include "cpu_defs.svh"

module datapath import cpu_pkg::*; (
    input  logic                  Clk,
    input  logic                  arst_n,
    output logic                  inst_read,
    output logic [`WORD_SIZE-1:0] inst_addr,
    input  logic [`WORD_SIZE-1:0] inst_data,
    output logic                  data_read,
    output logic                  data_write,
    output logic [`WORD_SIZE-1:0] data_addr,
    output logic [`WORD_SIZE-1:0] write_data,
    input  logic [`WORD_SIZE-1:0] read_data,
    output logic                  is_halted,
    output logic [`WORD_SIZE-1:0] num_inst,
    output logic [`WORD_SIZE-1:0] output_port,
    output instr_t                id_instruction,
    output logic                  id_valid,
    input  logic                  reg_dst,
    input  logic                  alu_src,
    input  logic                  mem_read,
    input  logic                  mem_write,
    input  logic                  mem_to_reg,
    input  logic                  reg_write,
    input  logic                  is_branch,
    input  logic                  is_jump,
    input  logic                  is_jump_reg,
    input  logic                  is_link,
    input  logic                  is_wwd,
    input  logic                  is_halt,
    input  alu_op_t               alu_op
);

    logic [`WORD_SIZE-1:0] pc;
    logic [`WORD_SIZE-1:0] ifid_pc;

    logic [3:0]            id_opcode;
    logic [1:0]            id_rs;
    logic [1:0]            id_rt;
    logic [1:0]            id_dest;
    logic                  id_use_rs;
    logic                  id_use_rt;
    logic [`WORD_SIZE-1:0] id_imm;
    logic [`WORD_SIZE-1:0] id_read1;
    logic [`WORD_SIZE-1:0] id_read2;
    logic [`WORD_SIZE-1:0] jump_target;

    logic                  idex_valid;
    logic [`WORD_SIZE-1:0] idex_pc1;
    logic [`WORD_SIZE-1:0] idex_read1;
    logic [`WORD_SIZE-1:0] idex_read2;
    logic [`WORD_SIZE-1:0] idex_imm;
    logic [1:0]            idex_rs;
    logic [1:0]            idex_rt;
    logic [1:0]            idex_dest;
    logic                  idex_alu_src;
    logic                  idex_mem_read;
    logic                  idex_mem_write;
    logic                  idex_mem_to_reg;
    logic                  idex_reg_write;
    logic                  idex_branch;
    logic                  idex_beq;
    logic                  idex_jump_reg;
    logic                  idex_link;
    logic                  idex_lhi;
    logic                  idex_wwd;
    logic                  idex_halt;
    alu_op_t               idex_alu_op;

    logic [1:0]            forward_a;
    logic [1:0]            forward_b;
    logic                  stall;
    logic [`WORD_SIZE-1:0] fwd_a;
    logic [`WORD_SIZE-1:0] fwd_b;
    logic [`WORD_SIZE-1:0] op_a;
    logic [`WORD_SIZE-1:0] op_b;
    logic [`WORD_SIZE-1:0] alu_result;
    logic                  alu_zero;
    logic                  ex_taken;
    logic                  ex_redirect;
    logic [`WORD_SIZE-1:0] ex_target;

    logic                  exmem_valid;
    logic [`WORD_SIZE-1:0] exmem_result;
    logic [`WORD_SIZE-1:0] exmem_store;
    logic [1:0]            exmem_dest;
    logic                  exmem_mem_read;
    logic                  exmem_mem_write;
    logic                  exmem_mem_to_reg;
    logic                  exmem_reg_write;
    logic                  exmem_wwd;
    logic                  exmem_halt;

    logic                  memwb_valid;
    logic [`WORD_SIZE-1:0] memwb_result;
    logic [`WORD_SIZE-1:0] memwb_load;
    logic [1:0]            memwb_dest;
    logic                  memwb_mem_to_reg;
    logic                  memwb_reg_write;
    logic                  memwb_wwd;
    logic                  memwb_halt;
    logic [`WORD_SIZE-1:0] wb_data;
    logic                  wb_write;

    // decode
    assign id_opcode = id_instruction.i_fmt.opcode;
    assign id_rs = id_instruction.r_fmt.rs;
    assign id_rt = id_instruction.r_fmt.rt;
    assign id_dest = is_link ? 2'd2 : (reg_dst ? id_instruction.r_fmt.rd : id_rt);
    assign id_imm = (id_opcode == `LHI_OP) ? {id_instruction.i_fmt.imm, 8'h00}
                                           : {{8{id_instruction.i_fmt.imm[7]}},
                                              id_instruction.i_fmt.imm};
    assign jump_target = {pc[15:12], id_instruction.j_fmt.target};
    assign id_use_rs = id_valid && id_opcode != `JMP_OP && id_opcode != `JAL_OP &&
                       id_opcode != `LHI_OP;
    assign id_use_rt = id_valid && (id_opcode == `BNE_OP || id_opcode == `BEQ_OP ||
                       id_opcode == `SWD_OP ||
                       (id_opcode == `RTYPE_OP && id_instruction.r_fmt.func[5:2] == 4'd0));

    // execute
    assign fwd_a = (forward_a == 2'b01) ? exmem_result :
                   (forward_a == 2'b10) ? wb_data : idex_read1;
    assign fwd_b = (forward_b == 2'b01) ? exmem_result :
                   (forward_b == 2'b10) ? wb_data : idex_read2;
    assign op_a = idex_link ? idex_pc1 : (idex_lhi ? idex_imm : fwd_a);
    assign op_b = idex_alu_src ? idex_imm : fwd_b;
    assign ex_taken = idex_valid && idex_branch && (idex_beq ? alu_zero : !alu_zero);
    assign ex_redirect = ex_taken || (idex_valid && idex_jump_reg);
    assign ex_target = idex_jump_reg ? fwd_a : idex_pc1 + idex_imm;

    // write-back; nothing past a retired HLT may write
    assign wb_data = memwb_mem_to_reg ? memwb_load : memwb_result;
    assign wb_write = memwb_valid && memwb_reg_write && !is_halted;

    assign inst_read = !is_halted;
    assign inst_addr = pc;
    assign data_read = exmem_valid && exmem_mem_read && !is_halted;
    assign data_write = exmem_valid && exmem_mem_write && !is_halted &&
                        !(memwb_valid && memwb_halt);
    assign data_addr = exmem_result;
    assign write_data = exmem_store;

    register_file regfile0 (
        .Clk,
        .arst_n,
        .read_addr1(id_rs),
        .read_addr2(id_rt),
        .write_addr(memwb_dest),
        .write_data(wb_data),
        .write_enable(wb_write),
        .read_data1(id_read1),
        .read_data2(id_read2)
    );

    alu alu0 (
        .operand_a(op_a),
        .operand_b(op_b),
        .alu_op(idex_alu_op),
        .result(alu_result),
        .zero(alu_zero)
    );

    hazard_forward hazard0 (
        .ex_rs(idex_rs),
        .ex_rt(idex_rt),
        .id_rs,
        .id_rt,
        .ex_rd(idex_dest),
        .mem_rd(exmem_dest),
        .wb_rd(memwb_dest),
        .id_use_rs,
        .id_use_rt,
        .ex_mem_read(idex_valid && idex_mem_read),
        .mem_reg_write(exmem_valid && exmem_reg_write),
        .wb_reg_write(wb_write),
        .forward_a,
        .forward_b,
        .stall
    );

    // PC, valid bits and retirement
    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
            id_valid <= 1'b0;
            idex_valid <= 1'b0;
            exmem_valid <= 1'b0;
            memwb_valid <= 1'b0;
            is_halted <= 1'b0;
            num_inst <= '0;
            output_port <= '0;
        end else if (!is_halted) begin
            exmem_valid <= idex_valid;
            memwb_valid <= exmem_valid;
            if (ex_redirect) begin
                pc <= ex_target;
                id_valid <= 1'b0;
                idex_valid <= 1'b0;
            end else if (stall) begin
                idex_valid <= 1'b0;
            end else if (is_jump) begin
                pc <= jump_target;
                id_valid <= 1'b0;
                idex_valid <= id_valid;
            end else begin
                pc <= pc + `WORD_SIZE'd1;
                id_valid <= 1'b1;
                idex_valid <= id_valid;
            end
            if (memwb_valid) begin
                num_inst <= num_inst + `WORD_SIZE'd1;
                if (memwb_wwd) begin
                    output_port <= memwb_result;
                end
                if (memwb_halt) begin
                    is_halted <= 1'b1;
                end
            end
        end
    end

    // pipeline payload
    always_ff @(posedge Clk) begin
        if (!is_halted) begin
            if (!stall) begin
                id_instruction <= inst_data;
                ifid_pc <= pc;
            end
            idex_pc1 <= ifid_pc + `WORD_SIZE'd1;
            idex_read1 <= id_read1;
            idex_read2 <= id_read2;
            idex_imm <= id_imm;
            idex_rs <= id_rs;
            idex_rt <= id_rt;
            idex_dest <= id_dest;
            idex_alu_src <= alu_src;
            idex_alu_op <= alu_op;
            idex_mem_read <= mem_read;
            idex_mem_write <= mem_write;
            idex_mem_to_reg <= mem_to_reg;
            idex_reg_write <= reg_write;
            idex_branch <= is_branch;
            idex_beq <= (id_opcode == `BEQ_OP);
            idex_jump_reg <= is_jump_reg;
            idex_link <= is_link;
            idex_lhi <= (id_opcode == `LHI_OP);
            idex_wwd <= is_wwd;
            idex_halt <= is_halt;

            exmem_result <= alu_result;
            exmem_store <= fwd_b;
            exmem_dest <= idex_dest;
            exmem_mem_read <= idex_mem_read;
            exmem_mem_write <= idex_mem_write;
            exmem_mem_to_reg <= idex_mem_to_reg;
            exmem_reg_write <= idex_reg_write;
            exmem_wwd <= idex_wwd;
            exmem_halt <= idex_halt;

            memwb_result <= exmem_result;
            memwb_load <= read_data;
            memwb_dest <= exmem_dest;
            memwb_mem_to_reg <= exmem_mem_to_reg;
            memwb_reg_write <= exmem_reg_write;
            memwb_wwd <= exmem_wwd;
            memwb_halt <= exmem_halt;
        end
    end

endmodule

//--- source/cpu_top.sv
`include "cpu_defs.svh"

module cpu_top import cpu_pkg::*; (
    input  logic                  Clk,
    input  logic                  arst_n,
    input  logic [`WORD_SIZE-1:0] inst_data,
    input  logic [`WORD_SIZE-1:0] read_data,
    output logic                  inst_read,
    output logic                  data_read,
    output logic                  data_write,
    output logic [`WORD_SIZE-1:0] inst_addr,
    output logic [`WORD_SIZE-1:0] data_addr,
    output logic [`WORD_SIZE-1:0] write_data,
    output logic [`WORD_SIZE-1:0] num_inst,
    output logic [`WORD_SIZE-1:0] output_port,
    output logic                  is_halted
);

    // decode latch contents and the control levels derived from it
    instr_t  id_instruction;
    logic    id_valid;
    logic    reg_dst;
    logic    alu_src;
    logic    mem_read;
    logic    mem_write;
    logic    mem_to_reg;
    logic    reg_write;
    logic    is_branch;
    logic    is_jump;
    logic    is_jump_reg;
    logic    is_link;
    logic    is_wwd;
    logic    is_halt;
    alu_op_t alu_op;

    control_unit control0 (.*);

    datapath datapath0 (.*);

endmodule

//--- test/tb_memory.sv
`include "cpu_defs.svh"

module tb_memory (
    input  logic                  Clk,
    input  logic                  inst_read,
    input  logic [`WORD_SIZE-1:0] inst_addr,
    output logic [`WORD_SIZE-1:0] inst_data,
    input  logic                  data_read,
    input  logic                  data_write,
    input  logic [`WORD_SIZE-1:0] data_addr,
    input  logic [`WORD_SIZE-1:0] write_data,
    output logic [`WORD_SIZE-1:0] read_data
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [`WORD_SIZE-1:0] inst_mem [256];
    logic [`WORD_SIZE-1:0] data_mem [256];

    // both memories answer within the cycle
    assign inst_data = inst_read ? inst_mem[inst_addr[7:0]] : '0;
    assign read_data = data_read ? data_mem[data_addr[7:0]] : '0;

    always @(posedge Clk) begin
        if (data_write) begin
            data_mem[data_addr[7:0]] <= write_data;
        end
    end

    // an unused instruction word jumps to itself, so a runaway fetch spins there
    task automatic fill_all();
        for (int i = 0; i < 256; i++) begin
            inst_mem[i] <= {`JMP_OP, 12'(i)};
            data_mem[i] <= 16'hC000 | 16'(i);
        end
    endtask

    task automatic load_inst(input int addr, input logic [15:0] word);
        inst_mem[addr] <= word;
    endtask

    task automatic load_data(input int addr, input logic [15:0] word);
        data_mem[addr] <= word;
    endtask

    function automatic logic [15:0] peek_data(input logic [7:0] addr);
        return data_mem[addr];
    endfunction

endmodule

//--- test/tb_cpu_top.sv
`include "cpu_defs.svh"

module tb_cpu_top;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_PROGS = 4;
    localparam int MAX_WORDS = 20;
    localparam int MAX_OUTS = 4;

    logic        Clk;
    logic        arst_n;
    logic [15:0] inst_data;
    logic [15:0] read_data;
    logic        inst_read;
    logic        data_read;
    logic        data_write;
    logic [15:0] inst_addr;
    logic [15:0] data_addr;
    logic [15:0] write_data;
    logic [15:0] num_inst;
    logic [15:0] output_port;
    logic        is_halted;

    // program table, one row per program
    logic [15:0] code [NUM_PROGS][MAX_WORDS];
    int          code_len [NUM_PROGS];
    logic [15:0] init_data [NUM_PROGS][4];
    logic [15:0] exp_out [NUM_PROGS][MAX_OUTS];
    int          exp_out_count [NUM_PROGS];
    logic [15:0] exp_num_inst [NUM_PROGS];
    logic [7:0]  check_addr [NUM_PROGS];
    logic [15:0] check_word [NUM_PROGS];

    int          fill_row;
    int          cur_row;
    int          out_idx;
    logic [15:0] last_out;
    logic        watching;
    logic        table_ready;
    int          errors;
    int          cycle_count;
    int          cycle_limit;

    cpu_top dut0 (.*);

    tb_memory mem0 (.*);

    initial begin
        Clk = 1'b0;
        forever #2 Clk = ~Clk;
    end

    function automatic logic [15:0] encode_reg(input logic [1:0] rs, rt, rd,
                                               input logic [5:0] func);
        return {`RTYPE_OP, rs, rt, rd, func};
    endfunction

    function automatic logic [15:0] encode_imm(input logic [3:0] op,
                                               input logic [1:0] rs, rt,
                                               input logic [7:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [15:0] encode_jump(input logic [3:0] op,
                                                input logic [11:0] target);
        return {op, target};
    endfunction

    task automatic add_word(input logic [15:0] word);
        code[fill_row][code_len[fill_row]] = word;
        code_len[fill_row]++;
    endtask

    task automatic add_output(input logic [15:0] value);
        exp_out[fill_row][exp_out_count[fill_row]] = value;
        exp_out_count[fill_row]++;
    endtask

    task automatic set_row_result(input logic [15:0] d0, d1, d2, d3,
                                  input logic [15:0] insts,
                                  input logic [7:0] addr,
                                  input logic [15:0] word);
        init_data[fill_row] = '{d0, d1, d2, d3};
        exp_num_inst[fill_row] = insts;
        check_addr[fill_row] = addr;
        check_word[fill_row] = word;
        fill_row++;
    endtask

    task automatic build_table();
        for (int p = 0; p < NUM_PROGS; p++) begin
            code_len[p] = 0;
            exp_out_count[p] = 0;
        end
        fill_row = 0;
        // ALU chain, every result used by the next instruction
        add_word(encode_imm(`LHI_OP, 0, 1, 8'h12));
        add_word(encode_imm(`ADI_OP, 1, 2, 8'hF5));
        add_word(encode_reg(2, 1, 3, `FUNC_ADD));
        add_word(encode_reg(3, 0, 0, `FUNC_WWD));
        add_word(encode_reg(3, 2, 0, `FUNC_SUB));
        add_word(encode_reg(0, 2, 1, `FUNC_AND));
        add_word(encode_reg(1, 0, 0, `FUNC_WWD));
        add_word(encode_reg(1, 3, 2, `FUNC_ORR));
        add_word(encode_reg(2, 0, 0, `FUNC_WWD));
        add_word(encode_reg(0, 0, 0, `FUNC_HLT));
        add_output(16'h23F5);
        add_output(16'h1000);
        add_output(16'h33F5);
        set_row_result(16'h1111, 16'h2222, 16'h3333, 16'h4444, 10, 8'h00, 16'h1111);
        // store, then loads with a dependent instruction right behind
        add_word(encode_imm(`ADI_OP, 0, 1, 8'h10));
        add_word(encode_imm(`LHI_OP, 0, 2, 8'h5A));
        add_word(encode_imm(`ADI_OP, 2, 2, 8'h3C));
        add_word(encode_imm(`SWD_OP, 1, 2, 8'h02));
        add_word(encode_imm(`LWD_OP, 1, 3, 8'h02));
        add_word(encode_reg(3, 1, 0, `FUNC_ADD));
        add_word(encode_reg(0, 0, 0, `FUNC_WWD));
        add_word(encode_imm(`LWD_OP, 1, 2, 8'hF1));
        add_word(encode_reg(2, 0, 0, `FUNC_WWD));
        add_word(encode_reg(0, 0, 0, `FUNC_HLT));
        add_output(16'h5A4C);
        add_output(16'h0777);
        set_row_result(16'h0123, 16'h0777, 16'h0ABC, 16'h0DEF, 10, 8'h12, 16'h5A3C);
        // branches and jumps; every WWD r0 sits on a flushed path
        add_word(encode_imm(`ADI_OP, 0, 1, 8'h01));
        add_word(encode_imm(`BEQ_OP, 1, 0, 8'h02));
        add_word(encode_reg(1, 0, 0, `FUNC_WWD));
        add_word(encode_imm(`BNE_OP, 1, 0, 8'h02));
        add_word(encode_reg(0, 0, 0, `FUNC_WWD));
        add_word(encode_reg(0, 0, 0, `FUNC_WWD));
        add_word(encode_imm(`ADI_OP, 1, 3, 8'h05));
        add_word(encode_imm(`BEQ_OP, 3, 3, 8'h01));
        add_word(encode_reg(0, 0, 0, `FUNC_WWD));
        add_word(encode_reg(3, 0, 0, `FUNC_WWD));
        add_word(encode_jump(`JAL_OP, 12'd14));
        add_word(encode_reg(2, 0, 0, `FUNC_WWD));
        add_word(encode_jump(`JMP_OP, 12'd17));
        add_word(encode_reg(0, 0, 0, `FUNC_WWD));
        add_word(encode_reg(3, 1, 3, `FUNC_ADD));
        add_word(encode_reg(3, 0, 0, `FUNC_WWD));
        add_word(encode_reg(2, 0, 0, `FUNC_JPR));
        add_word(encode_reg(0, 0, 0, `FUNC_HLT));
        add_output(16'h0001);
        add_output(16'h0006);
        add_output(16'h0007);
        add_output(16'h000B);
        set_row_result(16'hAAAA, 16'hBBBB, 16'hCCCC, 16'hDDDD, 14, 8'h03, 16'hDDDD);
        // nothing behind HLT may store or write the port
        add_word(encode_imm(`LHI_OP, 0, 1, 8'h7E));
        add_word(encode_imm(`ADI_OP, 1, 1, 8'h01));
        add_word(encode_reg(1, 0, 0, `FUNC_WWD));
        add_word(encode_imm(`ADI_OP, 0, 2, 8'h20));
        add_word(encode_imm(`SWD_OP, 2, 1, 8'h00));
        add_word(encode_reg(0, 0, 0, `FUNC_HLT));
        add_word(encode_imm(`SWD_OP, 2, 0, 8'h00));
        add_word(encode_reg(2, 0, 0, `FUNC_WWD));
        add_output(16'h7E01);
        set_row_result(16'h0F0F, 16'hF0F0, 16'h00FF, 16'hFF00, 6, 8'h20, 16'h7E01);
    endtask

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] expected);
        assert (got === expected) else begin
            errors++;
            $display("MISMATCH %s: got %h, expected %h (program %0d)",
                     name, got, expected, cur_row);
        end
    endtask

    // output_port settles after the rising edge, so look at it on the falling one
    always @(negedge Clk) begin
        if (watching && output_port !== last_out) begin
            assert (out_idx < exp_out_count[cur_row]) else begin
                errors++;
                $display("program %0d: unexpected extra output_port write of %h",
                         cur_row, output_port);
            end
            if (out_idx < exp_out_count[cur_row]) begin
                check_value("output_port", output_port, exp_out[cur_row][out_idx]);
            end
            out_idx++;
            last_out = output_port;
        end
    end

    task automatic run_program(input int p);
        @(posedge Clk);
        #1;
        arst_n = 1'b0;
        watching = 1'b0;
        cur_row = p;
        mem0.fill_all();
        for (int i = 0; i < code_len[p]; i++) begin
            mem0.load_inst(i, code[p][i]);
        end
        for (int i = 0; i < 4; i++) begin
            mem0.load_data(i, init_data[p][i]);
        end
        repeat (5) @(posedge Clk);
        #1;
        check_value("num_inst", num_inst, 16'h0000);
        check_value("output_port", output_port, 16'h0000);
        check_value("is_halted", is_halted, 16'h0000);
        check_value("inst_read", inst_read, 16'h0001);
        check_value("data_read", data_read, 16'h0000);
        check_value("data_write", data_write, 16'h0000);
        out_idx = 0;
        last_out = output_port;
        watching = 1'b1;
        arst_n = 1'b1;
        while (is_halted !== 1'b1) begin
            @(posedge Clk);
        end
        #1;
        check_value("num_inst", num_inst, exp_num_inst[p]);
        // the core must stay frozen once halted
        repeat (8) @(posedge Clk);
        #1;
        assert (is_halted === 1'b1 && inst_read === 1'b0) else begin
            errors++;
            $display("program %0d: core did not stay halted", p);
        end
        check_value("num_inst", num_inst, exp_num_inst[p]);
        check_value("output_port", output_port, exp_out[p][exp_out_count[p] - 1]);
        assert (out_idx == exp_out_count[p]) else begin
            errors++;
            $display("program %0d: saw %0d output_port writes, wanted %0d",
                     p, out_idx, exp_out_count[p]);
        end
        check_value("data_mem", mem0.peek_data(check_addr[p]), check_word[p]);
        watching = 1'b0;
    endtask

    initial begin
        arst_n = 1'b0;
        errors = 0;
        watching = 1'b0;
        table_ready = 1'b0;
        cur_row = 0;
        out_idx = 0;
        last_out = '0;
        mem0.fill_all();
        build_table();
        table_ready = 1'b1;
        for (int p = 0; p < NUM_PROGS; p++) begin
            run_program(p);
        end
        $display("run complete: %0d errors", errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // 40 cycles for every instruction word in the table
    initial begin
        cycle_count = 0;
        wait (table_ready);
        cycle_limit = 0;
        for (int p = 0; p < NUM_PROGS; p++) begin
            cycle_limit += 40 * code_len[p];
        end
        while (cycle_count < cycle_limit) begin
            @(posedge Clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, program %0d never reached is_halted",
                 cycle_count, cur_row);
        $display("run aborted: %0d errors", errors);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

//--- cpu_top.f
+incdir+include
source/cpu_pkg.sv
source/control_unit.sv
source/register_file.sv
source/alu.sv
source/hazard_forward.sv
source/datapath.sv
source/cpu_top.sv
test/tb_memory.sv
test/tb_cpu_top.sv

//--- Bender.yml
package:
  name: cpu_top

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/cpu_pkg.sv
      - source/control_unit.sv
      - source/register_file.sv
      - source/alu.sv
      - source/hazard_forward.sv
      - source/datapath.sv
      - source/cpu_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/tb_memory.sv
      - test/tb_cpu_top.sv
